// ==== rtl/chdr_pkg.sv ====
// --------------------------------------------------
// CHDR packet format: endpoint ID type, its place in
// the head word and the management word layout
// --------------------------------------------------
`default_nettype none

package chdr_pkg;

  // Destination endpoint ID carried by every packet
  typedef logic [15:0] epid_t;

  // --------------------------------------------------
  // Head word layout
  // --------------------------------------------------

  // The EPID sits in the low 16 bits of the head word
  localparam int EPID_LSB = 0;

  // --------------------------------------------------
  // Management word layout
  // --------------------------------------------------

  // One management word inserts one table entry
  localparam int MGMT_W = 32;

  // Bits 15:0 hold the EPID and the port field starts here.
  // The port field is as wide as the port index of the crossbar
  localparam int MGMT_PORT_LSB = 16;

endpackage : chdr_pkg

`default_nettype wire

// ==== rtl/xbar_pkg.sv ====
// --------------------------------------------------
// Crossbar internal state encodings
// --------------------------------------------------
`default_nettype none

package xbar_pkg;

  // Ingress buffer FSM.
  // ST_HEAD waits for a head word, ST_LOOKUP waits for the routing result,
  // ST_BODY streams the packet toward the chosen egress
  typedef enum logic [1:0] {
    ST_HEAD,
    ST_LOOKUP,
    ST_BODY
  } ingress_state_t;

  // Egress arbiter FSM.
  // ST_IDLE picks a source, ST_PACKET holds it until last
  typedef enum logic {
    ST_IDLE,
    ST_PACKET
  } egress_state_t;

endpackage : xbar_pkg

`default_nettype wire

// ==== rtl/route_table.sv ====
// --------------------------------------------------
// EPID to port routing table with FIFO replacement
// and round-robin arbitration of the lookups
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module route_table #(
  parameter int NUM_PORTS      = 4,
  parameter int ROUTE_TBL_SIZE = 3
) (
  input  logic                                              clk,
  input  logic                                              reset,
  // Management side port
  input  logic [chdr_pkg::MGMT_W-1:0]                       i_mgmt_data,
  input  logic                                              i_mgmt_valid,
  output logic                                              o_mgmt_ready,
  // Find requests, one per ingress
  input  logic [NUM_PORTS*$bits(chdr_pkg::epid_t)-1:0]      i_find_epid,
  input  logic [NUM_PORTS-1:0]                              i_find_valid,
  // Result, shared bus with a one-hot valid
  output logic [((NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1)-1:0] o_result_port,
  output logic                                              o_result_hit,
  output logic [NUM_PORTS-1:0]                              o_result_valid
);

  localparam int PORT_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int EPID_W  = $bits(chdr_pkg::epid_t);
  localparam int NUM_ENT = 2**ROUTE_TBL_SIZE;

  // Table storage, valid bits and the FIFO replacement pointer
  chdr_pkg::epid_t           ent_epid [NUM_ENT];
  logic [PORT_W-1:0]         ent_port [NUM_ENT];
  logic [NUM_ENT-1:0]        ent_valid;
  logic [ROUTE_TBL_SIZE-1:0] wr_ptr;

  logic                      mgmt_ready;
  logic                      ins_stb;
  chdr_pkg::epid_t           ins_epid;
  logic [PORT_W-1:0]         ins_port;
  logic                      ins_match;
  logic [ROUTE_TBL_SIZE-1:0] ins_idx;

  logic [NUM_PORTS-1:0]      req;
  logic [PORT_W-1:0]         last_grant;
  logic [PORT_W-1:0]         pick;
  chdr_pkg::epid_t           find_key;
  logic                      find_hit;
  logic [PORT_W-1:0]         find_port;

  // --------------------------------------------------
  // Management inserts
  // --------------------------------------------------

  assign o_mgmt_ready = mgmt_ready;
  assign ins_stb      = i_mgmt_valid && mgmt_ready;
  assign ins_epid     = i_mgmt_data[EPID_W-1:0];
  assign ins_port     = i_mgmt_data[chdr_pkg::MGMT_PORT_LSB +: PORT_W];

  // An EPID already in the table is updated where it lives
  always_comb begin
    ins_match = 1'b0;
    ins_idx   = '0;
    for (int e = 0; e < NUM_ENT; e++) begin
      if (ent_valid[e] && ent_epid[e] == ins_epid) begin
        ins_match = 1'b1;
        ins_idx   = ROUTE_TBL_SIZE'(e);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ins_stb) begin
      if (ins_match) begin
        ent_port[ins_idx] <= ins_port;
      end else begin
        ent_epid[wr_ptr] <= ins_epid;
        ent_port[wr_ptr] <= ins_port;
      end
    end
  end

  // A new EPID lands in the oldest slot, so the pointer walks the table in order
  always_ff @(posedge clk) begin
    if (reset) begin
      mgmt_ready <= 1'b0;
      ent_valid  <= '0;
      wr_ptr     <= '0;
    end else begin
      mgmt_ready <= 1'b1;
      if (ins_stb && !ins_match) begin
        ent_valid[wr_ptr] <= 1'b1;
        wr_ptr            <= wr_ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Lookup arbitration and compare
  // --------------------------------------------------

  // A requester whose result is on the bus this cycle still holds its
  // find valid, so it is masked out to avoid a second grant
  assign req = i_find_valid & ~o_result_valid;

  // Search starts one past the last grant
  always_comb begin
    int idx;
    logic found;
    pick  = last_grant;
    found = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(last_grant) + k) % NUM_PORTS;
      if (!found && req[idx]) begin
        pick  = PORT_W'(idx);
        found = 1'b1;
      end
    end
  end

  assign find_key = i_find_epid[pick*EPID_W +: EPID_W];

  // All entries are compared in parallel against the granted key
  always_comb begin
    find_hit  = 1'b0;
    find_port = '0;
    for (int e = 0; e < NUM_ENT; e++) begin
      if (ent_valid[e] && ent_epid[e] == find_key) begin
        find_hit  = 1'b1;
        find_port = ent_port[e];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant     <= '0;
      o_result_valid <= '0;
    end else begin
      o_result_valid <= '0;
      if (|req) begin
        last_grant     <= pick;
        o_result_valid <= NUM_PORTS'(1) << pick;
      end
    end
  end

  // Result payload, qualified by the one-hot valid
  always_ff @(posedge clk) begin
    o_result_port <= find_port;
    o_result_hit  <= find_hit;
  end

endmodule : route_table

`default_nettype wire

// ==== rtl/ingress_buffer.sv ====
// --------------------------------------------------
// Per-port packet FIFO with head lookup and steering
// toward one egress
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module ingress_buffer #(
  parameter int CHDR_W       = 64,
  parameter int NUM_PORTS    = 4,
  parameter int DEFAULT_PORT = 0,
  parameter int MTU          = 5
) (
  input  logic                  clk,
  input  logic                  reset,
  // Packet input
  input  logic [CHDR_W-1:0]     i_data,
  input  logic                  i_last,
  input  logic                  i_valid,
  output logic                  o_ready,
  // Routing table find request
  output chdr_pkg::epid_t       o_find_epid,
  output logic                  o_find_valid,
  // Routing table result
  input  logic [((NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1)-1:0] i_result_port,
  input  logic                  i_result_hit,
  input  logic                  i_result_valid,
  // Packet output, valid is one-hot across the egresses
  output logic [CHDR_W-1:0]     o_data,
  output logic                  o_last,
  output logic [NUM_PORTS-1:0]  o_valid,
  input  logic [NUM_PORTS-1:0]  i_ready
);

  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int DEPTH  = 2**MTU;

  // FIFO storage holds last alongside each word
  logic [CHDR_W:0]         mem [DEPTH];
  logic [MTU-1:0]          wr_ptr;
  logic [MTU-1:0]          rd_ptr;
  logic [MTU:0]            count;
  logic [MTU:0]            count_next;
  logic                    in_ready;
  logic                    push;
  logic                    pop;
  logic                    empty;
  logic [CHDR_W-1:0]       head_data;
  logic                    head_last;

  xbar_pkg::ingress_state_t state;
  logic [PORT_W-1:0]       dest;

  // --------------------------------------------------
  // Packet FIFO
  // --------------------------------------------------

  assign o_ready    = in_ready;
  assign push       = i_valid && in_ready;
  assign empty      = (count == '0);
  assign count_next = count + (MTU+1)'(push) - (MTU+1)'(pop);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {i_last, i_data};
    end
  end

  assign {head_last, head_data} = mem[rd_ptr];

  // Ready is registered from the occupancy that follows this cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      wr_ptr   <= wr_ptr + MTU'(push);
      rd_ptr   <= rd_ptr + MTU'(pop);
      count    <= count_next;
      in_ready <= (count_next < (MTU+1)'(DEPTH));
    end
  end

  // --------------------------------------------------
  // Lookup and steering FSM
  // --------------------------------------------------

  // The find stays up from the head cycle until the result comes back
  assign o_find_epid  = head_data[chdr_pkg::EPID_LSB +: $bits(chdr_pkg::epid_t)];
  assign o_find_valid = (state == xbar_pkg::ST_HEAD && !empty) ||
                        (state == xbar_pkg::ST_LOOKUP);

  // Only the latched egress sees valid, and only its ready can pop
  assign o_data  = head_data;
  assign o_last  = head_last;
  assign o_valid = (state == xbar_pkg::ST_BODY && !empty) ? (NUM_PORTS'(1) << dest) : '0;
  assign pop     = (state == xbar_pkg::ST_BODY) && !empty && i_ready[dest];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= xbar_pkg::ST_HEAD;
      dest  <= '0;
    end else begin
      case (state)
        xbar_pkg::ST_HEAD: begin
          if (!empty) begin
            state <= xbar_pkg::ST_LOOKUP;
          end
        end
        xbar_pkg::ST_LOOKUP: begin
          // A miss falls back to the default port
          if (i_result_valid) begin
            dest  <= i_result_hit ? i_result_port : PORT_W'(DEFAULT_PORT);
            state <= xbar_pkg::ST_BODY;
          end
        end
        xbar_pkg::ST_BODY: begin
          if (pop && head_last) begin
            state <= xbar_pkg::ST_HEAD;
          end
        end
        default: state <= xbar_pkg::ST_HEAD;
      endcase
    end
  end

endmodule : ingress_buffer

`default_nettype wire

// ==== rtl/egress_arbiter.sv ====
// --------------------------------------------------
// Per-port round-robin packet arbiter with a
// registered output stage
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module egress_arbiter #(
  parameter int CHDR_W    = 64,
  parameter int NUM_PORTS = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  // One lane per source ingress
  input  logic [NUM_PORTS*CHDR_W-1:0]   i_data,
  input  logic [NUM_PORTS-1:0]          i_last,
  input  logic [NUM_PORTS-1:0]          i_valid,
  output logic [NUM_PORTS-1:0]          o_ready,
  // Output port
  output logic [CHDR_W-1:0]             o_data,
  output logic                          o_last,
  output logic                          o_valid,
  input  logic                          i_ready
);

  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  xbar_pkg::egress_state_t state;
  logic [PORT_W-1:0]       grant;
  logic [PORT_W-1:0]       pick;
  logic                    out_free;
  logic                    take;

  // --------------------------------------------------
  // Source selection
  // --------------------------------------------------

  // Next requesting source after the one granted last
  always_comb begin
    int idx;
    logic found;
    pick  = grant;
    found = 1'b0;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(grant) + k) % NUM_PORTS;
      if (!found && i_valid[idx]) begin
        pick  = PORT_W'(idx);
        found = 1'b1;
      end
    end
  end

  // The output register can take a word when empty or draining
  assign out_free = !o_valid || i_ready;
  assign take     = (state == xbar_pkg::ST_PACKET) && i_valid[grant] && out_free;
  assign o_ready  = (state == xbar_pkg::ST_PACKET && out_free) ?
                    (NUM_PORTS'(1) << grant) : '0;

  // Grant is held from the head word until last is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= xbar_pkg::ST_IDLE;
      grant <= '0;
    end else begin
      case (state)
        xbar_pkg::ST_IDLE: begin
          if (|i_valid) begin
            grant <= pick;
            state <= xbar_pkg::ST_PACKET;
          end
        end
        xbar_pkg::ST_PACKET: begin
          if (take && i_last[grant]) begin
            state <= xbar_pkg::ST_IDLE;
          end
        end
        default: state <= xbar_pkg::ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else if (take) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Payload follows the accepted word one cycle later
  always_ff @(posedge clk) begin
    if (take) begin
      o_data <= i_data[grant*CHDR_W +: CHDR_W];
      o_last <= i_last[grant];
    end
  end

endmodule : egress_arbiter

`default_nettype wire

// ==== rtl/chdr_crossbar.sv ====
// --------------------------------------------------
// NxN CHDR crossbar top: shared routing table,
// ingress buffers, egress arbiters and the full mesh
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module chdr_crossbar #(
  parameter int CHDR_W         = 64,
  parameter int NUM_PORTS      = 4,
  parameter int DEFAULT_PORT   = 0,
  parameter int MTU            = 5,
  parameter int ROUTE_TBL_SIZE = 3
) (
  input  logic                        clk,
  input  logic                        reset,
  // Inputs, flattened per port
  input  logic [NUM_PORTS*CHDR_W-1:0] i_s_data,
  input  logic [NUM_PORTS-1:0]        i_s_last,
  input  logic [NUM_PORTS-1:0]        i_s_valid,
  output logic [NUM_PORTS-1:0]        o_s_ready,
  // Outputs, flattened per port
  output logic [NUM_PORTS*CHDR_W-1:0] o_m_data,
  output logic [NUM_PORTS-1:0]        o_m_last,
  output logic [NUM_PORTS-1:0]        o_m_valid,
  input  logic [NUM_PORTS-1:0]        i_m_ready,
  // Routing table management
  input  logic [chdr_pkg::MGMT_W-1:0] i_mgmt_data,
  input  logic                        i_mgmt_valid,
  output logic                        o_mgmt_ready
);

  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
  localparam int EPID_W = $bits(chdr_pkg::epid_t);

  // Lookup traffic between the ingresses and the table
  logic [NUM_PORTS*EPID_W-1:0] find_epid;
  logic [NUM_PORTS-1:0]        find_valid;
  logic [PORT_W-1:0]           result_port;
  logic                        result_hit;
  logic [NUM_PORTS-1:0]        result_valid;

  // Mesh seen from the ingress side, indexed by source
  logic [CHDR_W-1:0]           ing_data  [NUM_PORTS];
  logic                        ing_last  [NUM_PORTS];
  logic [NUM_PORTS-1:0]        ing_valid [NUM_PORTS];
  logic [NUM_PORTS-1:0]        ing_ready [NUM_PORTS];

  // Mesh seen from the egress side, indexed by destination
  logic [NUM_PORTS*CHDR_W-1:0] eg_data   [NUM_PORTS];
  logic [NUM_PORTS-1:0]        eg_last   [NUM_PORTS];
  logic [NUM_PORTS-1:0]        eg_valid  [NUM_PORTS];
  logic [NUM_PORTS-1:0]        eg_ready  [NUM_PORTS];

  route_table #(
    .NUM_PORTS      (NUM_PORTS),
    .ROUTE_TBL_SIZE (ROUTE_TBL_SIZE)
  ) u_route_table (
    .clk            (clk),
    .reset          (reset),
    .i_mgmt_data    (i_mgmt_data),
    .i_mgmt_valid   (i_mgmt_valid),
    .o_mgmt_ready   (o_mgmt_ready),
    .i_find_epid    (find_epid),
    .i_find_valid   (find_valid),
    .o_result_port  (result_port),
    .o_result_hit   (result_hit),
    .o_result_valid (result_valid)
  );

  for (genvar n = 0; n < NUM_PORTS; n++) begin : g_port
    ingress_buffer #(
      .CHDR_W         (CHDR_W),
      .NUM_PORTS      (NUM_PORTS),
      .DEFAULT_PORT   (DEFAULT_PORT),
      .MTU            (MTU)
    ) u_ingress (
      .clk            (clk),
      .reset          (reset),
      .i_data         (i_s_data[n*CHDR_W +: CHDR_W]),
      .i_last         (i_s_last[n]),
      .i_valid        (i_s_valid[n]),
      .o_ready        (o_s_ready[n]),
      .o_find_epid    (find_epid[n*EPID_W +: EPID_W]),
      .o_find_valid   (find_valid[n]),
      .i_result_port  (result_port),
      .i_result_hit   (result_hit),
      .i_result_valid (result_valid[n]),
      .o_data         (ing_data[n]),
      .o_last         (ing_last[n]),
      .o_valid        (ing_valid[n]),
      .i_ready        (ing_ready[n])
    );

    egress_arbiter #(
      .CHDR_W         (CHDR_W),
      .NUM_PORTS      (NUM_PORTS)
    ) u_egress (
      .clk            (clk),
      .reset          (reset),
      .i_data         (eg_data[n]),
      .i_last         (eg_last[n]),
      .i_valid        (eg_valid[n]),
      .o_ready        (eg_ready[n]),
      .o_data         (o_m_data[n*CHDR_W +: CHDR_W]),
      .o_last         (o_m_last[n]),
      .o_valid        (o_m_valid[n]),
      .i_ready        (i_m_ready[n])
    );
  end

  // --------------------------------------------------
  // Mesh transpose, source by destination
  // --------------------------------------------------

  for (genvar d = 0; d < NUM_PORTS; d++) begin : g_dst
    for (genvar s = 0; s < NUM_PORTS; s++) begin : g_src
      assign eg_data[d][s*CHDR_W +: CHDR_W] = ing_data[s];
      assign eg_last[d][s]                  = ing_last[s];
      assign eg_valid[d][s]                 = ing_valid[s][d];
      assign ing_ready[s][d]                = eg_ready[d][s];
    end
  end

endmodule : chdr_crossbar

`default_nettype wire

// ==== verif/chdr_crossbar_assert.sv ====
// --------------------------------------------------
// Concurrent checks on the crossbar output ports
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module chdr_crossbar_assert #(
  parameter int CHDR_W    = 64,
  parameter int NUM_PORTS = 4
) (
  input logic                        clk,
  input logic                        reset,
  input logic [NUM_PORTS-1:0]        o_s_ready,
  input logic [NUM_PORTS*CHDR_W-1:0] o_m_data,
  input logic [NUM_PORTS-1:0]        o_m_last,
  input logic [NUM_PORTS-1:0]        o_m_valid,
  input logic [NUM_PORTS-1:0]        i_m_ready,
  input logic                        o_mgmt_ready
);

  // Every valid and ready is low in the cycle that follows a reset cycle
  a_reset_quiet: assert property (@(posedge clk)
    reset |=> (o_m_valid == '0) && (o_s_ready == '0) && !o_mgmt_ready)
    else $error("Crossbar outputs active right after reset");

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    logic        fire;
    logic        in_pkt;
    // Source and sequence tag that the test traffic carries in bits 63:40
    logic [23:0] tag;

    assign fire = o_m_valid[p] && i_m_ready[p];

    always_ff @(posedge clk) begin
      if (reset) begin
        in_pkt <= 1'b0;
      end else if (fire) begin
        in_pkt <= !o_m_last[p];
        if (!in_pkt) begin
          tag <= o_m_data[p*CHDR_W+40 +: 24];
        end
      end
    end

    // A stalled word stays put until the sink takes it
    a_hold: assert property (@(posedge clk) disable iff (reset)
      o_m_valid[p] && !i_m_ready[p] |=>
        o_m_valid[p] && $stable(o_m_data[p*CHDR_W +: CHDR_W]) && $stable(o_m_last[p]))
      else $error("Output %0d changed while stalled", p);

    // Words after the head belong to the same packet up to last
    a_one_packet: assert property (@(posedge clk) disable iff (reset)
      fire && in_pkt |-> o_m_data[p*CHDR_W+40 +: 24] == tag)
      else $error("Output %0d mixed two packets", p);
  end

endmodule : chdr_crossbar_assert

bind chdr_crossbar chdr_crossbar_assert #(
  .CHDR_W       (CHDR_W),
  .NUM_PORTS    (NUM_PORTS)
) u_chdr_crossbar_assert (
  .clk          (clk),
  .reset        (reset),
  .o_s_ready    (o_s_ready),
  .o_m_data     (o_m_data),
  .o_m_last     (o_m_last),
  .o_m_valid    (o_m_valid),
  .i_m_ready    (i_m_ready),
  .o_mgmt_ready (o_mgmt_ready)
);

`default_nettype wire

// ==== verif/tb_chdr_crossbar.sv ====
// --------------------------------------------------
// Crossbar testbench with LFSR traffic, a routing
// table model, per-output checker and timeout
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module tb_chdr_crossbar;

  localparam int CHDR_W       = 64;
  localparam int NUM_PORTS    = 4;
  localparam int DEFAULT_PORT = 3;
  localparam int TBL_ENTRIES  = 8;
  localparam int SRC_DEPTH    = 512;
  localparam int LANE_DEPTH   = 512;
  localparam int RR_PORT      = 2;
  // Total packet count of all sources and tests, where each packet is at most 8 words long
  localparam int TOTAL_PKTS   = NUM_PORTS * (16 + 4 + 8 + 9 + 16 + 4);
  localparam int CYCLE_LIMIT  = 4 * TOTAL_PKTS * 8 + 2000;

  logic                        clk;
  logic                        reset;
  logic [NUM_PORTS*CHDR_W-1:0] i_s_data;
  logic [NUM_PORTS-1:0]        i_s_last;
  logic [NUM_PORTS-1:0]        i_s_valid;
  logic [NUM_PORTS-1:0]        o_s_ready;
  logic [NUM_PORTS*CHDR_W-1:0] o_m_data;
  logic [NUM_PORTS-1:0]        o_m_last;
  logic [NUM_PORTS-1:0]        o_m_valid;
  logic [NUM_PORTS-1:0]        i_m_ready;
  logic [31:0]                 i_mgmt_data;
  logic                        i_mgmt_valid;
  logic                        o_mgmt_ready;

  // Stimulus words per source and expected words per output and source lane
  logic [CHDR_W:0] src_mem [0:NUM_PORTS*SRC_DEPTH-1];
  logic [CHDR_W:0] exp_mem [0:NUM_PORTS*NUM_PORTS*LANE_DEPTH-1];
  int              src_ptr [NUM_PORTS];
  int              src_end [NUM_PORTS];
  logic            src_acc [NUM_PORTS];
  int              seq     [NUM_PORTS];
  int              exp_rd  [NUM_PORTS*NUM_PORTS];
  int              exp_wr  [NUM_PORTS*NUM_PORTS];
  int              in_pkt  [NUM_PORTS];
  int              cur_src [NUM_PORTS];
  int              exp_total;
  int              rcv_total;
  int              err_cnt;
  int              cycles;

  // Table model with FIFO replacement
  logic [15:0]     mdl_epid  [TBL_ENTRIES];
  int              mdl_port  [TBL_ENTRIES];
  logic            mdl_valid [TBL_ENTRIES];
  int              mdl_ptr;
  logic [15:0]     ev_epid   [9];

  logic [31:0]     lfsr;
  logic            gap_en;
  logic            bp_en;
  logic            rr_rec;
  logic [NUM_PORTS-1:0] hold_out;
  int              rr_src [0:63];
  int              rr_cnt;

  chdr_crossbar #(
    .CHDR_W         (CHDR_W),
    .NUM_PORTS      (NUM_PORTS),
    .DEFAULT_PORT   (DEFAULT_PORT),
    .MTU            (5),
    .ROUTE_TBL_SIZE (3)
  ) dut0 (
    .clk            (clk),
    .reset          (reset),
    .i_s_data       (i_s_data),
    .i_s_last       (i_s_last),
    .i_s_valid      (i_s_valid),
    .o_s_ready      (o_s_ready),
    .o_m_data       (o_m_data),
    .o_m_last       (o_m_last),
    .o_m_valid      (o_m_valid),
    .i_m_ready      (i_m_ready),
    .i_mgmt_data    (i_mgmt_data),
    .i_mgmt_valid   (i_mgmt_valid),
    .o_mgmt_ready   (o_mgmt_ready)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // Random bits, checks and the table model
  // --------------------------------------------------

  // Galois LFSR stepped once for each bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Simulation stopped");
    end
  endtask

  // Miss goes to the default port
  function automatic int route_of(input logic [15:0] epid);
    int port;
    port = DEFAULT_PORT;
    for (int e = 0; e < TBL_ENTRIES; e++) begin
      if (mdl_valid[e] && mdl_epid[e] == epid) port = mdl_port[e];
    end
    return port;
  endfunction

  // Table EPIDs keep bit 15 low, so any EPID with bit 15 set is a miss
  function automatic logic [15:0] fresh_epid();
    logic [15:0] e;
    logic        used;
    do begin
      e    = {1'b0, 15'(rand_bits(15))};
      used = 1'b0;
      for (int k = 0; k < TBL_ENTRIES; k++) begin
        if (mdl_valid[k] && mdl_epid[k] == e) used = 1'b1;
      end
    end while (used);
    return e;
  endfunction

  task automatic program_entry(input logic [15:0] epid, input int port);
    int hit;
    @(negedge clk);
    i_mgmt_data         = '0;
    i_mgmt_data[15:0]   = epid;
    i_mgmt_data[16 +: 2] = port[1:0];
    i_mgmt_valid        = 1'b1;
    @(posedge clk);
    while (!o_mgmt_ready) @(posedge clk);
    // Same EPID updates in place while a new one replaces the oldest slot
    hit = -1;
    for (int e = 0; e < TBL_ENTRIES; e++) begin
      if (mdl_valid[e] && mdl_epid[e] == epid) hit = e;
    end
    if (hit >= 0) begin
      mdl_port[hit] = port;
    end else begin
      mdl_epid[mdl_ptr]  = epid;
      mdl_port[mdl_ptr]  = port;
      mdl_valid[mdl_ptr] = 1'b1;
      mdl_ptr            = (mdl_ptr + 1) % TBL_ENTRIES;
    end
    @(negedge clk);
    i_mgmt_valid = 1'b0;
  endtask

  // Head word is {source, sequence, zero, EPID} and body words carry the word index
  task automatic queue_packet(input int s, input logic [15:0] epid, input int len);
    logic [63:0] w;
    int          lane;
    lane = route_of(epid) * NUM_PORTS + s;
    if (src_end[s] + len > SRC_DEPTH) abort_run("Stimulus memory too small for the test");
    for (int i = 0; i < len; i++) begin
      if (i == 0) w = {8'(s), 16'(seq[s]), 24'h0, epid};
      else w = {8'(s), 16'(seq[s]), 8'(i), rand_bits(32)};
      src_mem[s*SRC_DEPTH + src_end[s]]    = {(i == len - 1), w};
      exp_mem[lane*LANE_DEPTH + exp_wr[lane]] = {(i == len - 1), w};
      src_end[s]++;
      exp_wr[lane]++;
    end
    exp_total += len;
    seq[s]++;
  endtask

  task automatic wait_drained();
    while (rcv_total != exp_total) @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  // --------------------------------------------------
  // Drivers, monitor and timeout
  // --------------------------------------------------

  // A word is held until accepted and gaps only open between words
  always @(negedge clk) begin
    if (!reset) begin
      for (int s = 0; s < NUM_PORTS; s++) begin
        if (!(i_s_valid[s] && !src_acc[s])) begin
          if (src_ptr[s] < src_end[s] && (!gap_en || rand_bits(1) != 0)) begin
            i_s_valid[s] = 1'b1;
            {i_s_last[s], i_s_data[s*CHDR_W +: CHDR_W]} = src_mem[s*SRC_DEPTH + src_ptr[s]];
          end else begin
            i_s_valid[s] = 1'b0;
          end
        end
        src_acc[s] = 1'b0;
      end
      for (int d = 0; d < NUM_PORTS; d++) begin
        i_m_ready[d] = hold_out[d] ? 1'b0 : (bp_en ? rand_bits(1) != 0 : 1'b1);
      end
    end
  end

  always @(posedge clk) begin : port_monitor
    int          src;
    int          lane;
    logic [64:0] exp_w;
    if (!reset) begin
      for (int s = 0; s < NUM_PORTS; s++) begin
        if (i_s_valid[s] && o_s_ready[s]) begin
          src_ptr[s]++;
          src_acc[s] = 1'b1;
        end
      end
      for (int d = 0; d < NUM_PORTS; d++) begin
        if (o_m_valid[d] && i_m_ready[d]) begin
          // The head word names its source, later words follow it
          src  = (in_pkt[d] != 0) ? cur_src[d] : int'(o_m_data[d*CHDR_W+56 +: 8]);
          lane = d * NUM_PORTS + src;
          if (src >= NUM_PORTS) begin
            abort_run($sformatf("Output %0d sent a head word with an unknown source", d));
          end else if (exp_rd[lane] == exp_wr[lane]) begin
            abort_run($sformatf("Output %0d sent a word from source %0d that was not routed there",
                                d, src));
          end else begin
            exp_w = exp_mem[lane*LANE_DEPTH + exp_rd[lane]];
            check_value($sformatf("o_m_data[%0d]", d), o_m_data[d*CHDR_W +: CHDR_W], exp_w[63:0]);
            check_value($sformatf("o_m_last[%0d]", d), 64'(o_m_last[d]), 64'(exp_w[64]));
            if (rr_rec && d == RR_PORT && in_pkt[d] == 0) begin
              rr_src[rr_cnt] = src;
              rr_cnt++;
            end
            exp_rd[lane]++;
            rcv_total++;
            in_pkt[d]  = o_m_last[d] ? 0 : 1;
            cur_src[d] = src;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) abort_run("Timeout: traffic did not drain in time");
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    logic [15:0] epid;
    int          len;
    int          k;
    clk = 1'b0;
    reset = 1'b1;
    i_s_data = '0;
    i_s_last = '0;
    i_s_valid = '0;
    i_m_ready = '0;
    i_mgmt_data = '0;
    i_mgmt_valid = 1'b0;
    lfsr = 32'h6584f3a5;
    {gap_en, bp_en, rr_rec, hold_out} = '0;
    {exp_total, rcv_total, err_cnt, cycles, rr_cnt, mdl_ptr} = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      {src_ptr[i], src_end[i], seq[i], in_pkt[i], cur_src[i]} = '0;
      src_acc[i] = 1'b0;
    end
    for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) {exp_rd[i], exp_wr[i]} = '0;
    for (int i = 0; i < TBL_ENTRIES; i++) mdl_valid[i] = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Routing through a table full of random entries
    for (int i = 0; i < TBL_ENTRIES; i++) program_entry(fresh_epid(), rand_bits(2));
    @(posedge clk);
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < 16; j++) begin
        epid = mdl_epid[rand_bits(3)];
        len  = 1 + rand_bits(3);
        queue_packet(s, epid, len);
      end
    end
    wait_drained();

    // Missing EPIDs fall to the default port
    @(posedge clk);
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < 4; j++) begin
        epid = {1'b1, 15'(rand_bits(15))};
        len  = 1 + rand_bits(3);
        queue_packet(s, epid, len);
      end
    end
    wait_drained();

    // Move one entry other than the oldest to another port while every other entry survives
    k = (mdl_ptr + 1 + rand_bits(3) % (TBL_ENTRIES - 1)) % TBL_ENTRIES;
    program_entry(mdl_epid[k], (mdl_port[k] + 1) % NUM_PORTS);
    @(posedge clk);
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < TBL_ENTRIES; j++) begin
        len = 1 + rand_bits(3);
        queue_packet(s, mdl_epid[j], len);
      end
    end
    wait_drained();

    // Nine new EPIDs push the first of them out again
    // The first one maps away from the default port so that its eviction shows
    for (int i = 0; i < 9; i++) begin
      ev_epid[i] = fresh_epid();
      program_entry(ev_epid[i], (i == 0) ? (DEFAULT_PORT + 1) % NUM_PORTS : rand_bits(2));
    end
    @(posedge clk);
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < 9; j++) begin
        len = 1 + rand_bits(3);
        queue_packet(s, ev_epid[j], len);
      end
    end
    wait_drained();

    // Random input gaps and random output stalls
    @(posedge clk);
    gap_en = 1'b1;
    bp_en  = 1'b1;
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < 16; j++) begin
        epid = mdl_epid[rand_bits(3)];
        len  = 1 + rand_bits(3);
        queue_packet(s, epid, len);
      end
    end
    wait_drained();
    gap_en = 1'b0;
    bp_en  = 1'b0;

    // All sources queue up behind one stalled output
    epid = fresh_epid();
    program_entry(epid, RR_PORT);
    @(posedge clk);
    hold_out[RR_PORT] = 1'b1;
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int j = 0; j < 4; j++) begin
        len = 1 + rand_bits(3);
        queue_packet(s, epid, (len < 2) ? 2 : len);
      end
    end
    repeat (150) @(posedge clk);
    rr_rec            = 1'b1;
    hold_out[RR_PORT] = 1'b0;
    wait_drained();
    rr_rec = 1'b0;
    check_value("rr_packets", 64'(rr_cnt), 64'(4 * NUM_PORTS));
    for (int i = 1; i < rr_cnt; i++) begin
      check_value("rr_source", 64'(rr_src[i]), 64'((rr_src[i-1] + 1) % NUM_PORTS));
    end

    if (err_cnt == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "Mismatches found");
    end
  end

endmodule : tb_chdr_crossbar

`default_nettype wire

// ==== chdr_crossbar.f ====
rtl/chdr_pkg.sv
rtl/xbar_pkg.sv
rtl/route_table.sv
rtl/ingress_buffer.sv
rtl/egress_arbiter.sv
rtl/chdr_crossbar.sv
verif/chdr_crossbar_assert.sv
verif/tb_chdr_crossbar.sv
